// File: csa_pkg.sv
package csa_pkg;

	localparam int DATA_W = 32; // bus and fifo word.
	localparam int ADDR_W = 10; // register address.

	// job as read from the input fifo; first word lands in the low bits.
	typedef struct packed {
		logic [DATA_W-1:0] times_start;
		logic [DATA_W-1:0] times;
		logic [2*DATA_W-1:0] cipher_in;
		logic [DATA_W-1:0] block;
	} csa_job_t;

	typedef struct packed {
		logic [2*DATA_W-1:0] cipher_out;
		csa_job_t job;
	} csa_result_t;

	typedef enum logic [ADDR_W-1:0] {
		REG_CHANNEL = 10'd0,
		REG_IN_VALID = 10'd1,
		REG_IN_DATA_0 = 10'd2,
		REG_IN_DATA_1 = 10'd3,
		REG_IN_DATA_2 = 10'd4,
		REG_IN_DATA_3 = 10'd5,
		REG_IN_DATA_4 = 10'd6,
		REG_OUT_VALID = 10'd7,
		REG_OUT_DATA_0 = 10'd8,
		REG_OUT_DATA_1 = 10'd9,
		REG_OUT_DATA_2 = 10'd10,
		REG_OUT_DATA_3 = 10'd11,
		REG_OUT_DATA_4 = 10'd12,
		REG_OUT_DATA_5 = 10'd13,
		REG_OUT_DATA_6 = 10'd14,
		REG_DEVICE_IDLE = 10'd15,
		REG_DEVICE_READY = 10'd16,
		REG_RESET = 10'd17
	} reg_addr_e;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_READ, // strobes out, words coming back.
		FETCH_SCAN
	} fetch_state_e;

	typedef enum logic {
		COLL_SCAN,
		COLL_SEND
	} collect_state_e;

endpackage

// File: csa_regs.sv
`timescale 1ns/1ps

module csa_regs #(
	parameter int N_UNITS = 4
) (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic wen_i,
	input logic [csa_pkg::ADDR_W-1:0] waddr_i,
	input logic [csa_pkg::DATA_W-1:0] wdata_i,
	input logic ren_i,
	input logic [csa_pkg::ADDR_W-1:0] raddr_i,
	input csa_pkg::csa_job_t in_mirror_i,
	input logic in_valid_i,
	input csa_pkg::csa_result_t out_mirror_i,
	input logic out_valid_i,
	input logic fifo_empty_i,
	input logic downstream_valid_i,
	output logic [csa_pkg::DATA_W-1:0] rdata_o,
	output logic [$clog2(N_UNITS)-1:0] channel_o,
	output logic channel_changed_o,
	output logic user_rst_n_o
);

	localparam int DATA_W = csa_pkg::DATA_W;
	localparam int ADDR_W = csa_pkg::ADDR_W;

	logic [4:0][DATA_W-1:0] in_words;
	logic [6:0][DATA_W-1:0] out_words;
	logic [2:0] in_sel;

	assign in_words = in_mirror_i;
	assign out_words = out_mirror_i;
	assign in_sel = raddr_i[2:0] - 3'd2; // in data sits at 2..6.

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			channel_o <= '0;
			channel_changed_o <= 1'b0;
			user_rst_n_o <= 1'b1;
		end else begin
			channel_changed_o <= 1'b0;
			user_rst_n_o <= 1'b1; // low for one cycle only.
			if (wen_i) begin
				case (waddr_i)
					csa_pkg::REG_CHANNEL: begin
						if (wdata_i < DATA_W'(N_UNITS)) begin
							channel_o <= wdata_i[$clog2(N_UNITS)-1:0];
							channel_changed_o <= 1'b1;
						end
					end
					csa_pkg::REG_RESET: begin
						user_rst_n_o <= wdata_i[0];
					end
					default: begin
					end
				endcase
			end
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			rdata_o <= '0;
		end else if (ren_i) begin
			case (raddr_i)
				csa_pkg::REG_CHANNEL: rdata_o <= DATA_W'(channel_o);
				csa_pkg::REG_IN_VALID: rdata_o <= DATA_W'(in_valid_i);
				csa_pkg::REG_IN_DATA_0, csa_pkg::REG_IN_DATA_1, csa_pkg::REG_IN_DATA_2,
				csa_pkg::REG_IN_DATA_3, csa_pkg::REG_IN_DATA_4: begin
					rdata_o <= in_words[in_sel];
				end
				csa_pkg::REG_OUT_VALID: rdata_o <= DATA_W'(out_valid_i);
				csa_pkg::REG_OUT_DATA_0, csa_pkg::REG_OUT_DATA_1, csa_pkg::REG_OUT_DATA_2,
				csa_pkg::REG_OUT_DATA_3, csa_pkg::REG_OUT_DATA_4, csa_pkg::REG_OUT_DATA_5,
				csa_pkg::REG_OUT_DATA_6: begin
					rdata_o <= out_words[raddr_i[2:0]]; // 8..14 maps to 0..6.
				end
				csa_pkg::REG_DEVICE_IDLE: rdata_o <= DATA_W'(fifo_empty_i);
				csa_pkg::REG_DEVICE_READY: rdata_o <= DATA_W'(downstream_valid_i);
				csa_pkg::REG_RESET: rdata_o <= DATA_W'(user_rst_n_o);
				default: rdata_o <= {16'he000, {(16 - ADDR_W){1'b0}}, raddr_i};
			endcase
		end
	end

endmodule

// File: csa_in_fetch.sv
`timescale 1ns/1ps

module csa_in_fetch #(
	parameter int N_UNITS = 4
) (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic fifo_rdy_i,
	input logic [csa_pkg::DATA_W-1:0] csa_in_rdata_i,
	input logic [N_UNITS-1:0] unit_full_i,
	input logic [$clog2(N_UNITS)-1:0] channel_i,
	input logic channel_changed_i,
	output logic csa_in_ren_o,
	output csa_pkg::csa_job_t unit_job_o,
	output logic [N_UNITS-1:0] unit_wen_o,
	output csa_pkg::csa_job_t in_mirror_o,
	output logic in_valid_o
);

	localparam int UNIT_W = $clog2(N_UNITS);
	localparam int JOB_W = $bits(csa_pkg::csa_job_t);

	csa_pkg::fetch_state_e state_q;
	logic [2:0] cnt_q;
	logic [UNIT_W-1:0] idx_q;
	logic [UNIT_W-1:0] idx_next;
	csa_pkg::csa_job_t job_q;

	assign idx_next = (idx_q == UNIT_W'(N_UNITS - 1)) ? '0 : idx_q + 1'b1;
	assign unit_job_o = job_q;

	// words arrive two cycles after their strobe, shifted in from the top.
	always_ff @(posedge axi_mm_clk) begin
		if (state_q == csa_pkg::FETCH_READ && cnt_q >= 3'd2) begin
			job_q <= csa_pkg::csa_job_t'({csa_in_rdata_i, job_q[JOB_W-1:csa_pkg::DATA_W]});
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state_q <= csa_pkg::FETCH_IDLE;
			cnt_q <= '0;
			idx_q <= '0;
			csa_in_ren_o <= 1'b0;
			unit_wen_o <= '0;
			in_mirror_o <= '0;
			in_valid_o <= 1'b0;
		end else begin
			csa_in_ren_o <= 1'b0;
			unit_wen_o <= '0;
			if (channel_changed_i) begin
				in_valid_o <= 1'b0;
			end
			case (state_q)
				csa_pkg::FETCH_IDLE: begin
					if (fifo_rdy_i) begin
						csa_in_ren_o <= 1'b1; // first of five.
						cnt_q <= '0;
						state_q <= csa_pkg::FETCH_READ;
					end
				end
				csa_pkg::FETCH_READ: begin
					csa_in_ren_o <= (cnt_q < 3'd4);
					cnt_q <= cnt_q + 3'd1;
					if (cnt_q == 3'd6) begin
						state_q <= csa_pkg::FETCH_SCAN; // last word in this edge.
					end
				end
				csa_pkg::FETCH_SCAN: begin
					idx_q <= idx_next;
					if (!unit_full_i[idx_q]) begin
						unit_wen_o[idx_q] <= 1'b1;
						if (idx_q == channel_i) begin
							in_mirror_o <= job_q;
							in_valid_o <= 1'b1;
						end
						state_q <= csa_pkg::FETCH_IDLE;
					end
				end
				default: begin
					state_q <= csa_pkg::FETCH_IDLE;
				end
			endcase
		end
	end

endmodule

// File: csa_out_collect.sv
`timescale 1ns/1ps

module csa_out_collect #(
	parameter int N_UNITS = 4
) (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic [N_UNITS-1:0] unit_ready_i,
	input csa_pkg::csa_result_t [N_UNITS-1:0] unit_result_i,
	input logic csa_out_full_i,
	input logic [$clog2(N_UNITS)-1:0] channel_i,
	input logic channel_changed_i,
	output logic [N_UNITS-1:0] unit_ren_o,
	output logic csa_out_wen_o,
	output logic [csa_pkg::DATA_W-1:0] csa_out_wdata_o,
	output csa_pkg::csa_result_t out_mirror_o,
	output logic out_valid_o
);

	localparam int UNIT_W = $clog2(N_UNITS);

	csa_pkg::collect_state_e state_q;
	logic [2:0] cnt_q;
	logic [UNIT_W-1:0] idx_q;
	logic [UNIT_W-1:0] idx_next;
	logic hit;
	csa_pkg::csa_result_t result_q;
	logic [6:0][csa_pkg::DATA_W-1:0] words;

	assign idx_next = (idx_q == UNIT_W'(N_UNITS - 1)) ? '0 : idx_q + 1'b1;
	assign hit = (state_q == csa_pkg::COLL_SCAN) && unit_ready_i[idx_q];

	// word order follows the struct layout, block first.
	assign words = result_q;
	assign csa_out_wdata_o = words[cnt_q];
	assign csa_out_wen_o = (state_q == csa_pkg::COLL_SEND) && !csa_out_full_i;

	always_ff @(posedge axi_mm_clk) begin
		if (hit) begin
			result_q <= unit_result_i[idx_q];
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state_q <= csa_pkg::COLL_SCAN;
			cnt_q <= '0;
			idx_q <= '0;
			unit_ren_o <= '0;
			out_mirror_o <= '0;
			out_valid_o <= 1'b0;
		end else begin
			unit_ren_o <= '0;
			if (channel_changed_i) begin
				out_valid_o <= 1'b0;
			end
			case (state_q)
				csa_pkg::COLL_SCAN: begin
					idx_q <= idx_next; // next unit either way.
					if (hit) begin
						unit_ren_o[idx_q] <= 1'b1; // pop, result latched now.
						cnt_q <= '0;
						if (idx_q == channel_i) begin
							out_mirror_o <= unit_result_i[idx_q];
							out_valid_o <= 1'b1;
						end
						state_q <= csa_pkg::COLL_SEND;
					end
				end
				csa_pkg::COLL_SEND: begin
					if (csa_out_wen_o) begin
						cnt_q <= cnt_q + 3'd1;
						if (cnt_q == 3'd6) begin
							state_q <= csa_pkg::COLL_SCAN;
						end
					end
				end
				default: begin
					state_q <= csa_pkg::COLL_SCAN;
				end
			endcase
		end
	end

endmodule

// File: csa_top.sv
`timescale 1ns/1ps

module csa_top #(
	parameter int N_UNITS = 4
) (
	input logic axi_mm_clk,
	input logic rst_n,
	output logic user_rst_n_o,
	input logic wen_i,
	input logic [csa_pkg::ADDR_W-1:0] waddr_i,
	input logic [csa_pkg::DATA_W-1:0] wdata_i,
	input logic ren_i,
	input logic [csa_pkg::ADDR_W-1:0] raddr_i,
	output logic [csa_pkg::DATA_W-1:0] rdata_o,
	input logic fifo_rdy_i,
	input logic fifo_empty_i,
	output logic csa_in_ren_o,
	input logic [csa_pkg::DATA_W-1:0] csa_in_rdata_i,
	input logic [N_UNITS-1:0] unit_full_i,
	output logic [N_UNITS-1:0] unit_wen_o,
	output csa_pkg::csa_job_t unit_job_o,
	input logic [N_UNITS-1:0] unit_ready_i,
	output logic [N_UNITS-1:0] unit_ren_o,
	input csa_pkg::csa_result_t [N_UNITS-1:0] unit_result_i,
	input logic downstream_valid_i,
	input logic csa_out_full_i,
	output logic csa_out_wen_o,
	output logic [csa_pkg::DATA_W-1:0] csa_out_wdata_o
);

	logic [$clog2(N_UNITS)-1:0] channel;
	logic channel_changed;
	csa_pkg::csa_job_t in_mirror;
	logic in_valid;
	csa_pkg::csa_result_t out_mirror;
	logic out_valid;

	csa_regs #(.N_UNITS(N_UNITS)) u_regs (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wen_i(wen_i),
		.waddr_i(waddr_i),
		.wdata_i(wdata_i),
		.ren_i(ren_i),
		.raddr_i(raddr_i),
		.in_mirror_i(in_mirror),
		.in_valid_i(in_valid),
		.out_mirror_i(out_mirror),
		.out_valid_i(out_valid),
		.fifo_empty_i(fifo_empty_i),
		.downstream_valid_i(downstream_valid_i),
		.rdata_o(rdata_o),
		.channel_o(channel),
		.channel_changed_o(channel_changed),
		.user_rst_n_o(user_rst_n_o)
	);

	csa_in_fetch #(.N_UNITS(N_UNITS)) u_in_fetch (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.fifo_rdy_i(fifo_rdy_i),
		.csa_in_rdata_i(csa_in_rdata_i),
		.unit_full_i(unit_full_i),
		.channel_i(channel),
		.channel_changed_i(channel_changed),
		.csa_in_ren_o(csa_in_ren_o),
		.unit_job_o(unit_job_o),
		.unit_wen_o(unit_wen_o),
		.in_mirror_o(in_mirror),
		.in_valid_o(in_valid)
	);

	csa_out_collect #(.N_UNITS(N_UNITS)) u_out_collect (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.unit_ready_i(unit_ready_i),
		.unit_result_i(unit_result_i),
		.csa_out_full_i(csa_out_full_i),
		.channel_i(channel),
		.channel_changed_i(channel_changed),
		.unit_ren_o(unit_ren_o),
		.csa_out_wen_o(csa_out_wen_o),
		.csa_out_wdata_o(csa_out_wdata_o),
		.out_mirror_o(out_mirror),
		.out_valid_o(out_valid)
	);

endmodule

// File: csa_checker.sv
`timescale 1ns/1ps

module csa_checker #(
	parameter int N_UNITS = 4
) (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic wen_i,
	input logic [csa_pkg::ADDR_W-1:0] waddr_i,
	input logic [csa_pkg::DATA_W-1:0] wdata_i,
	input logic ren_i,
	input logic [csa_pkg::ADDR_W-1:0] raddr_i,
	input logic [csa_pkg::DATA_W-1:0] rdata_o,
	input logic fifo_empty_i,
	input logic downstream_valid_i,
	input logic csa_in_ren_o,
	input logic [N_UNITS-1:0] unit_full_i,
	input logic [N_UNITS-1:0] unit_wen_o,
	input csa_pkg::csa_job_t unit_job_o,
	input logic [N_UNITS-1:0] unit_ready_i,
	input logic [N_UNITS-1:0] unit_ren_o,
	input csa_pkg::csa_result_t [N_UNITS-1:0] unit_result_i,
	input logic csa_out_full_i,
	input logic csa_out_wen_o,
	input logic [csa_pkg::DATA_W-1:0] csa_out_wdata_o,
	input logic user_rst_n_o,
	input logic job_push_i,
	input csa_pkg::csa_job_t job_i,
	output logic [4:0][15:0] err_o,
	output int checks_o,
	output int results_o
);

	csa_pkg::csa_job_t exp_jobs[$];
	logic [31:0] exp_words[$];
	logic [N_UNITS-1:0] ready_q;
	csa_pkg::csa_result_t [N_UNITS-1:0] res_q;
	logic [4:0][31:0] in_m;
	logic [6:0][31:0] out_m;
	int wait_cnt;
	int ptr;
	int exp_unit;
	int chan;
	int words_out;
	int rd_test;
	int ren_run;
	bit scanning;
	bit ren_q;
	bit clr_pend;
	bit exp_urst_n;
	bit in_v;
	bit out_v;
	bit rd_pend;
	logic [31:0] rd_exp;

	function automatic logic [4:0][31:0] job_words(input csa_pkg::csa_job_t j);
		logic [4:0][31:0] w;
		w[0] = j.block;
		w[1] = j.cipher_in[31:0];
		w[2] = j.cipher_in[63:32];
		w[3] = j.times;
		w[4] = j.times_start;
		return w;
	endfunction

	function automatic logic [6:0][31:0] result_words(input csa_pkg::csa_result_t r);
		logic [6:0][31:0] w;
		w[4:0] = job_words(r.job);
		w[5] = r.cipher_out[31:0];
		w[6] = r.cipher_out[63:32];
		return w;
	endfunction

	// register value as software should see it.
	function automatic logic [31:0] reg_model(input logic [9:0] a);
		if (a == 10'd0) return 32'(chan);
		if (a == 10'd1) return 32'(in_v);
		if (a >= 10'd2 && a <= 10'd6) return in_m[3'(a - 10'd2)];
		if (a == 10'd7) return 32'(out_v);
		if (a >= 10'd8 && a <= 10'd14) return out_m[3'(a - 10'd8)];
		if (a == 10'd15) return 32'(fifo_empty_i);
		if (a == 10'd16) return 32'(downstream_valid_i);
		if (a == 10'd17) return 32'(exp_urst_n);
		return {16'he000, 6'd0, a}; // unmapped.
	endfunction

	task automatic fail_val(input int t, input string name, input logic [223:0] got,
			input logic [223:0] exp);
		$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
		err_o[t] = err_o[t] + 16'd1;
	endtask

	task automatic fail_msg(input int t, input string what);
		$display("error: %s", what);
		err_o[t] = err_o[t] + 16'd1;
	endtask

	initial begin
		err_o = '0;
		checks_o = 0;
		results_o = 0;
	end

	always @(posedge axi_mm_clk) begin
		int u;
		logic [31:0] w;
		logic [6:0][31:0] rw;
		if (job_push_i) exp_jobs.push_back(job_i);
		if (!rst_n) begin
			ptr = 0;
			scanning = 0;
			wait_cnt = 0;
			exp_unit = -1;
			chan = 0;
			clr_pend = 0;
			exp_urst_n = 1;
			in_v = 0;
			out_v = 0;
			rd_pend = 0;
			ren_q = 0;
			ren_run = 0;
			ready_q = '0;
		end else begin
			// dispatch decided on the previous edge
			if (exp_unit >= 0) begin
				checks_o++;
				if (unit_wen_o != (N_UNITS'(1) << exp_unit)) begin
					fail_val(0, "unit_wen_o", 224'(unit_wen_o), 224'(N_UNITS'(1) << exp_unit));
				end else if (exp_jobs.size() == 0) begin
					fail_msg(0, "a job was dispatched but none was queued");
				end else begin
					if (unit_job_o != exp_jobs[0]) begin
						fail_val(0, "unit_job_o", 224'(unit_job_o), 224'(exp_jobs[0]));
					end
					if (exp_unit == chan) begin
						in_m = job_words(exp_jobs[0]);
						in_v = 1;
					end
					void'(exp_jobs.pop_front());
				end
			end else if (unit_wen_o != '0) begin
				fail_val(0, "unit_wen_o", 224'(unit_wen_o), 224'(0));
			end
			exp_unit = -1;
			if (wait_cnt > 0) begin
				wait_cnt--;
				if (wait_cnt == 0) scanning = 1; // last word is in.
			end
			if (scanning) begin
				if (!unit_full_i[ptr]) begin
					exp_unit = ptr;
					scanning = 0;
				end
				ptr = (ptr + 1) % N_UNITS;
			end
			if (csa_in_ren_o && !ren_q) begin
				if (scanning) begin
					fail_msg(0, "a read burst started before the last job was dispatched");
				end
				wait_cnt = 7;
			end
			if (csa_in_ren_o) begin
				ren_run++;
			end else if (ren_run != 0) begin
				checks_o++;
				if (ren_run != 5) begin
					fail_msg(0, "the input FIFO read burst was not five strobes long");
				end
				ren_run = 0;
			end
			ren_q = csa_in_ren_o;

			// result pop and output stream
			if (unit_ren_o != '0) begin
				u = 0;
				for (int i = 0; i < N_UNITS; i++) if (unit_ren_o[i]) u = i;
				if ($countones(unit_ren_o) != 1 || !ready_q[u]) begin
					fail_msg(1, "a unit was popped that was not ready");
				end
				rw = result_words(res_q[u]);
				for (int i = 0; i < 7; i++) exp_words.push_back(rw[i]);
				if (u == chan) begin
					out_m = rw;
					out_v = 1;
				end
			end
			if (csa_out_wen_o) begin
				checks_o++;
				if (csa_out_full_i) fail_msg(1, "output write while the FIFO was full");
				if (exp_words.size() == 0) begin
					fail_msg(1, "output write with no result pending");
				end else begin
					w = exp_words.pop_front();
					if (csa_out_wdata_o != w) fail_val(1, "csa_out_wdata_o", 224'(csa_out_wdata_o), 224'(w));
					words_out++;
					if (words_out % 7 == 0) results_o++;
				end
			end else if (exp_words.size() > 0 && !csa_out_full_i) begin
				fail_msg(1, "the output stream stalled while the FIFO had room");
			end
			ready_q = unit_ready_i;
			res_q = unit_result_i;

			// register reads, one cycle of latency
			if (rd_pend) begin
				checks_o++;
				if (rdata_o != rd_exp) fail_val(rd_test, "rdata_o", 224'(rdata_o), 224'(rd_exp));
			end
			rd_pend = ren_i;
			if (ren_i) begin
				rd_exp = reg_model(raddr_i);
				rd_test = (raddr_i <= 10'd14) ? 2 : ((raddr_i == 10'd17) ? 4 : 3);
			end

			checks_o++;
			if (user_rst_n_o != exp_urst_n) begin
				fail_val(4, "user_rst_n_o", 224'(user_rst_n_o), 224'(exp_urst_n));
			end
			exp_urst_n = !(wen_i && waddr_i == 10'd17 && !wdata_i[0]);

			if (clr_pend) begin
				in_v = 0;
				out_v = 0;
				clr_pend = 0;
			end
			if (wen_i && waddr_i == 10'd0 && wdata_i < 32'(N_UNITS)) begin
				chan = int'(wdata_i);
				clr_pend = 1;
			end
		end
	end

endmodule

// File: tb_csa.sv
`timescale 1ns/1ps

module tb_csa;

	localparam int N_UNITS = 4;
	localparam int N_BATCH = 4;
	localparam int PER_BATCH = 6;
	localparam int N_JOBS = N_BATCH * PER_BATCH;
	localparam int LIMIT = 20 * N_JOBS * (12 + N_UNITS);

	logic axi_mm_clk;
	logic rst_n;
	logic user_rst_n_o;
	logic wen_i;
	logic [9:0] waddr_i;
	logic [31:0] wdata_i;
	logic ren_i;
	logic [9:0] raddr_i;
	logic [31:0] rdata_o;
	logic fifo_rdy_i;
	logic fifo_empty_i;
	logic csa_in_ren_o;
	logic [31:0] csa_in_rdata_i;
	logic [N_UNITS-1:0] unit_full_i;
	logic [N_UNITS-1:0] unit_wen_o;
	csa_pkg::csa_job_t unit_job_o;
	logic [N_UNITS-1:0] unit_ready_i;
	logic [N_UNITS-1:0] unit_ren_o;
	csa_pkg::csa_result_t [N_UNITS-1:0] unit_result_i;
	logic downstream_valid_i;
	logic csa_out_full_i;
	logic csa_out_wen_o;
	logic [31:0] csa_out_wdata_o;
	logic job_push;
	csa_pkg::csa_job_t job_new;
	logic [4:0][15:0] err;
	int checks;
	int results;
	int cycles;
	int total;
	logic [31:0] in_fifo[$];
	logic [31:0] s1;
	logic [31:0] s2;
	csa_pkg::csa_result_t uq[N_UNITS][$];

	csa_top #(.N_UNITS(N_UNITS)) u_dut (.*);

	csa_checker #(.N_UNITS(N_UNITS)) u_chk (
		.*,
		.job_push_i(job_push),
		.job_i(job_new),
		.err_o(err),
		.checks_o(checks),
		.results_o(results)
	);

	always #20 axi_mm_clk = ~axi_mm_clk;

	always @(posedge axi_mm_clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	// input FIFO with two cycles of read latency, unit models, output FIFO
	always @(negedge axi_mm_clk) begin
		csa_pkg::csa_result_t r;
		if (rst_n) begin
			csa_in_rdata_i = s2;
			s2 = s1;
			s1 = (csa_in_ren_o && in_fifo.size() > 0) ? in_fifo.pop_front() : 32'h0;
			fifo_rdy_i = in_fifo.size() >= 5;
			fifo_empty_i = in_fifo.size() == 0;
			for (int u = 0; u < N_UNITS; u++) begin
				if (unit_ren_o[u]) void'(uq[u].pop_front());
				if (unit_wen_o[u]) begin
					r.job = unit_job_o;
					r.cipher_out = {$urandom, $urandom};
					uq[u].push_back(r);
				end
				unit_full_i[u] = (uq[u].size() >= 3) || ($urandom % 3 == 0);
				unit_ready_i[u] = (uq[u].size() > 0) && ($urandom % 2 == 0);
				unit_result_i[u] = (uq[u].size() > 0) ? uq[u][0] : '0;
			end
			csa_out_full_i = ($urandom % 4 == 0);
			downstream_valid_i = ($urandom % 2 == 0);
		end
	end

	task automatic write_reg(input logic [9:0] a, input logic [31:0] d);
		@(negedge axi_mm_clk);
		wen_i = 1'b1;
		waddr_i = a;
		wdata_i = d;
		@(negedge axi_mm_clk);
		wen_i = 1'b0;
	endtask

	task automatic read_reg(input logic [9:0] a);
		@(negedge axi_mm_clk);
		ren_i = 1'b1;
		raddr_i = a;
		@(negedge axi_mm_clk);
		ren_i = 1'b0;
	endtask

	task automatic add_job();
		@(negedge axi_mm_clk);
		job_new.block = $urandom;
		job_new.cipher_in = {$urandom, $urandom};
		job_new.times = $urandom;
		job_new.times_start = $urandom;
		in_fifo.push_back(job_new.block);
		in_fifo.push_back(job_new.cipher_in[31:0]);
		in_fifo.push_back(job_new.cipher_in[63:32]);
		in_fifo.push_back(job_new.times);
		in_fifo.push_back(job_new.times_start);
		job_push = 1'b1;
		@(negedge axi_mm_clk);
		job_push = 1'b0;
	endtask

	initial begin
		void'($urandom(52));
		axi_mm_clk = 1'b0;
		rst_n = 1'b0;
		{wen_i, ren_i, job_push, fifo_rdy_i, csa_out_full_i, downstream_valid_i} = '0;
		fifo_empty_i = 1'b1;
		{waddr_i, raddr_i, wdata_i, csa_in_rdata_i, s1, s2} = '0;
		{unit_full_i, unit_ready_i, unit_result_i, job_new} = '0;
		cycles = 0;
		repeat (4) @(posedge axi_mm_clk);
		@(negedge axi_mm_clk);
		rst_n = 1'b1;
		for (int b = 0; b < N_BATCH; b++) begin
			write_reg(10'd0, 32'(b % N_UNITS));
			if (b == N_BATCH - 1) write_reg(10'd0, 32'(N_UNITS + 5)); // out of range.
			read_reg(10'd1); // valids cleared by the channel write.
			read_reg(10'd7);
			for (int j = 0; j < PER_BATCH; j++) add_job();
			read_reg(10'd15); // jobs still queued here.
			while (results < (b + 1) * PER_BATCH) @(negedge axi_mm_clk);
			repeat (4) @(negedge axi_mm_clk);
			for (int a = 0; a <= 17; a++) read_reg(10'(a));
			read_reg(10'h100 + 10'(b));
			write_reg(10'd17, 32'd0);
			read_reg(10'd17);
		end
		repeat (3) @(negedge axi_mm_clk);
		$display("dispatch: %0d errors", err[0]);
		$display("result stream: %0d errors", err[1]);
		$display("channel mirror: %0d errors", err[2]);
		$display("status and unmapped reads: %0d errors", err[3]);
		$display("user reset: %0d errors", err[4]);
		total = int'(err[0]) + int'(err[1]) + int'(err[2]) + int'(err[3]) + int'(err[4]);
		$display("%0d checks, %0d errors, %0d results", checks, total, results);
		if (total == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
csa_pkg.sv
csa_regs.sv
csa_in_fetch.sv
csa_out_collect.sv
csa_top.sv
csa_checker.sv
tb_csa.sv

// File: Makefile
TOOL = verilator
FLAGS = --binary --timing -j 0
TOP = tb_csa
FLIST = src.f
PASS = Result: PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir
